// File: common/fetch_defines.svh
`ifndef FETCH_DEFINES_SVH
`define FETCH_DEFINES_SVH

// Address and instruction width
`define FETCH_ADDR_W 32

// First fetch address after reset
`define FETCH_RESET_PC 32'h1c000000

// Words behind the instruction memory model
`define FETCH_MEM_DEPTH 4096

// Discarded responses still owed by memory, at most three
`define FETCH_DISCARD_W 2

`endif

// File: common/fetch_pkg.sv
`default_nettype none

package fetch_pkg;

    // Redirect sources, ordered so a larger value wins
    typedef enum logic [1:0] {
        REDIR_NONE      = 2'd0,
        REDIR_BRANCH    = 2'd1,
        REDIR_ERTN      = 2'd2,
        REDIR_EXCEPTION = 2'd3
    } redirect_kind_e;

    // Exception codes raised by the frontend
    typedef enum logic [5:0] {
        ECODE_NONE = 6'd0,
        ECODE_ADEF = 6'd8   // Fetch address error
    } ecode_e;

endpackage

`default_nettype wire

// File: common/fetch_stage_if.sv
`timescale 1ns/1ps
`default_nettype none
`include "fetch_defines.svh"

// IF to IW pipeline beat
interface fetch_stage_if;
    logic                     valid;
    logic                     ready;
    logic [`FETCH_ADDR_W-1:0] pc;
    logic [`FETCH_ADDR_W-1:0] inst;
    logic                     inst_valid;    // Word already returned while in IF
    logic                     discard_req;   // IF dropped a request with data owed
    logic                     has_exception;
    fetch_pkg::ecode_e        ecode;
    logic [8:0]               esubcode;

    modport src (
        output valid,
        input  ready,
        output pc,
        output inst,
        output inst_valid,
        output discard_req,
        output has_exception,
        output ecode,
        output esubcode
    );

    modport dst (
        input  valid,
        output ready,
        input  pc,
        input  inst,
        input  inst_valid,
        input  discard_req,
        input  has_exception,
        input  ecode,
        input  esubcode
    );
endinterface

`default_nettype wire

// File: common/imem_if.sv
`timescale 1ns/1ps
`default_nettype none
`include "fetch_defines.svh"

// SRAM-like instruction port, responses in request order
interface imem_if;
    logic                     req;
    logic [`FETCH_ADDR_W-1:0] addr;
    logic                     addr_ok;   // Request accepted this cycle
    logic                     data_ok;   // One word back this cycle
    logic [`FETCH_ADDR_W-1:0] rdata;

    modport master (
        output req,
        output addr,
        input  addr_ok,
        input  data_ok,
        input  rdata
    );

    modport slave (
        input  req,
        input  addr,
        output addr_ok,
        output data_ok,
        output rdata
    );
endinterface

`default_nettype wire

// File: sim.f
+incdir+common
common/fetch_pkg.sv
common/imem_if.sv
common/fetch_stage_if.sv
src/fetch_ctrl.sv
src/pc_gen.sv
src/inst_wait.sv
src/fetch_top.sv
sim/imem_model.sv
sim/tb_fetch.sv

// File: sim/imem_model.sv
`timescale 1ns/1ps
`default_nettype none
`include "fetch_defines.svh"

// Instruction memory with random accept and return delays, responses in order
module imem_model (
    input  logic                     clk,
    input  logic                     rst,
    input  logic                     req,
    input  logic [`FETCH_ADDR_W-1:0] addr,
    output logic                     addr_ok,
    output logic                     data_ok,
    output logic [`FETCH_ADDR_W-1:0] rdata
);
    logic [`FETCH_ADDR_W-1:0] addr_q[$];
    int unsigned              due_q[$];
    int unsigned              cycle;
    int unsigned              accept_wait;   // Cycles left before the next accept

    // Contents depend on the full address
    function automatic logic [`FETCH_ADDR_W-1:0] word_at(input logic [`FETCH_ADDR_W-1:0] a);
        return {a[24:0], a[31:25]} ^ 32'h5a5a_0f0f;
    endfunction

    assign addr_ok = req && (accept_wait == 0);

    always @(posedge clk) begin
        if (rst) begin
            cycle       <= 0;
            accept_wait <= $urandom_range(3);
            data_ok     <= 1'b0;
            rdata       <= '0;
            addr_q.delete();
            due_q.delete();
        end else begin
            cycle <= cycle + 1;
            if (req && addr_ok) begin
                addr_q.push_back(addr);
                due_q.push_back(cycle + $urandom_range(3));
                accept_wait <= $urandom_range(3);
            end else if (req) begin
                accept_wait <= accept_wait - 1;
            end
            data_ok <= 1'b0;
            // Earliest return is the cycle after accept
            if (due_q.size() != 0 && due_q[0] <= cycle) begin
                data_ok <= 1'b1;
                rdata   <= word_at(addr_q.pop_front());
                void'(due_q.pop_front());
            end
        end
    end
endmodule

`default_nettype wire

// File: sim/tb_fetch.sv
`timescale 1ns/1ps
`default_nettype none
`include "fetch_defines.svh"

module tb_fetch;
    localparam int PHASES      = 6;
    localparam int PHASE_LIMIT = 200;

    logic                     clk;
    logic                     rst;
    logic                     br_taken;
    logic                     ertn_flush;
    logic                     ex_flush;
    logic [`FETCH_ADDR_W-1:0] br_target;
    logic [`FETCH_ADDR_W-1:0] era;
    logic [`FETCH_ADDR_W-1:0] ex_entry;
    logic                     mem_req;
    logic [`FETCH_ADDR_W-1:0] mem_addr;
    logic                     mem_addr_ok;
    logic                     mem_data_ok;
    logic [`FETCH_ADDR_W-1:0] mem_rdata;
    logic                     out_valid;
    logic                     out_ready;
    logic [`FETCH_ADDR_W-1:0] out_inst;
    logic [`FETCH_ADDR_W-1:0] out_pc;
    logic                     has_exception;
    fetch_pkg::ecode_e        ecode;
    logic [8:0]               esubcode;

    logic [`FETCH_ADDR_W-1:0] exp_pc;      // Next PC downstream should see
    logic [`FETCH_ADDR_W-1:0] held_pc;
    logic [`FETCH_ADDR_W-1:0] held_inst;
    logic                     stalled;
    int                       delivered;

    initial clk = 1'b0;
    always #2 clk = ~clk;

    fetch_top dut0 (.*);

    imem_model u_mem (
        .clk     (clk),
        .rst     (rst),
        .req     (mem_req),
        .addr    (mem_addr),
        .addr_ok (mem_addr_ok),
        .data_ok (mem_data_ok),
        .rdata   (mem_rdata)
    );

    // Word stored at pc, rotated left by 7 and scrambled
    function automatic logic [`FETCH_ADDR_W-1:0] expected_inst(input logic [`FETCH_ADDR_W-1:0] pc);
        return {pc[24:0], pc[31:25]} ^ 32'h5a5a_0f0f;
    endfunction

    function automatic logic [`FETCH_ADDR_W-1:0] aligned_target();
        return $urandom() & 32'hffff_fffc;
    endfunction

    task automatic abort_run(input string why);
        $display("%s", why);
        $display("Simulation finished: FAIL");
        $fatal(1, "run stopped at first error");
    endtask

    task automatic check_inst(input string name, input logic [`FETCH_ADDR_W-1:0] actual,
                              input logic [`FETCH_ADDR_W-1:0] expected);
        if (actual !== expected) begin
            abort_run($sformatf("[FAIL] %s: got %h, expected %h", name, actual, expected));
        end
    endtask

    task automatic check_pc(input string name, input logic [`FETCH_ADDR_W-1:0] actual,
                            input logic [`FETCH_ADDR_W-1:0] expected);
        if (actual !== expected) begin
            abort_run($sformatf("[FAIL] %s: got %h, expected %h", name, actual, expected));
        end
    endtask

    task automatic check_exc(input fetch_pkg::ecode_e actual, input logic exc,
                             input logic [8:0] sub, input fetch_pkg::ecode_e expected);
        logic exp_exc;
        exp_exc = (expected != fetch_pkg::ECODE_NONE);
        if (actual !== expected) begin
            abort_run($sformatf("[FAIL] ecode: got %h, expected %h", actual, expected));
        end
        if (exc !== exp_exc) begin
            abort_run($sformatf("[FAIL] has_exception: got %h, expected %h", exc, exp_exc));
        end
        if (sub !== 9'h000) begin
            abort_run($sformatf("[FAIL] esubcode: got %h, expected %h", sub, 9'h000));
        end
    endtask

    task automatic check_beat();
        check_pc("out_pc", out_pc, exp_pc);
        if (exp_pc[1:0] == 2'b00) begin
            check_exc(ecode, has_exception, esubcode, fetch_pkg::ECODE_NONE);
            check_inst("out_inst", out_inst, expected_inst(exp_pc));
        end else begin
            check_exc(ecode, has_exception, esubcode, fetch_pkg::ECODE_ADEF);
        end
    endtask

    task automatic wait_beats(input int n);
        int target;
        target = delivered + n;
        while (delivered < target) begin
            @(posedge clk);
        end
    endtask

    // kinds is {exception, ertn, branch}
    task automatic drive_redirect(input logic [2:0] kinds, input logic [`FETCH_ADDR_W-1:0] ex_pc,
                                  input logic [`FETCH_ADDR_W-1:0] er_pc,
                                  input logic [`FETCH_ADDR_W-1:0] br_pc);
        @(posedge clk);
        ex_flush   <= kinds[2];
        ertn_flush <= kinds[1];
        br_taken   <= kinds[0];
        ex_entry   <= ex_pc;
        era        <= er_pc;
        br_target  <= br_pc;
    endtask

    task automatic end_redirect();
        @(posedge clk);
        ex_flush   <= 1'b0;
        ertn_flush <= 1'b0;
        br_taken   <= 1'b0;
    endtask

    // Sampled mid-cycle, so the handshake of the coming edge is settled
    always @(negedge clk) begin
        if (rst) begin
            exp_pc    = `FETCH_RESET_PC;
            stalled   = 1'b0;
            delivered = 0;
        end else begin
            if (mem_req && mem_addr[1:0] != 2'b00) begin
                abort_run($sformatf("memory request issued for misaligned address %h", mem_addr));
            end
            if (stalled) begin
                if (!out_valid) begin
                    abort_run("out_valid dropped while downstream was stalled");
                end
                check_pc("out_pc", out_pc, held_pc);
                check_inst("out_inst", out_inst, held_inst);
            end
            stalled = 1'b0;
            if (ex_flush || ertn_flush || br_taken) begin
                exp_pc = ex_flush ? ex_entry : (ertn_flush ? era : br_target);
            end else if (out_valid && out_ready) begin
                check_beat();
                exp_pc    = exp_pc + 32'd4;
                delivered = delivered + 1;
            end else if (out_valid) begin
                stalled   = 1'b1;
                held_pc   = out_pc;
                held_inst = out_inst;
            end
        end
    end

    initial begin
        repeat (10 + PHASES * PHASE_LIMIT) @(posedge clk);
        abort_run("watchdog expired before all test phases completed");
    end

    initial begin
        int k;
        void'($urandom(32'hbe01));
        rst        = 1'b1;
        br_taken   = 1'b0;
        ertn_flush = 1'b0;
        ex_flush   = 1'b0;
        br_target  = '0;
        era        = '0;
        ex_entry   = '0;
        out_ready  = 1'b0;
        repeat (10) @(posedge clk);
        rst       <= 1'b0;
        out_ready <= 1'b1;
        wait_beats(16);   // Sequential fetch from reset

        repeat (120) begin
            @(posedge clk);
            out_ready <= 1'($urandom_range(1));
        end
        @(posedge clk);
        out_ready <= 1'b1;
        wait_beats(2);

        // Branches landing at random points of the memory latency
        repeat (8) begin
            repeat ($urandom_range(5)) @(posedge clk);
            drive_redirect(3'b001, '0, '0, aligned_target());
            end_redirect();
            wait_beats(3);
        end

        for (k = 1; k < 8; k++) begin
            drive_redirect(3'(k), aligned_target(), aligned_target(), aligned_target());
            end_redirect();
            wait_beats(2);
        end

        // Misaligned target gives ADEF beats, then a clean return
        drive_redirect(3'b001, '0, '0, aligned_target() | 32'h2);
        end_redirect();
        wait_beats(3);
        drive_redirect(3'b010, '0, aligned_target(), '0);
        end_redirect();
        wait_beats(3);

        // Redirect bursts while downstream is stalled
        repeat (3) begin
            out_ready <= 1'b0;
            repeat (6) @(posedge clk);
            drive_redirect(3'b001, '0, '0, aligned_target());
            drive_redirect(3'b001, '0, '0, aligned_target());
            drive_redirect(3'b011, '0, aligned_target(), aligned_target());
            drive_redirect(3'b100, aligned_target(), '0, '0);
            end_redirect();
            repeat (4) @(posedge clk);
            out_ready <= 1'b1;
            wait_beats(6);
        end

        $display("Simulation finished: PASS");
        $finish;
    end
endmodule

`default_nettype wire

// File: src/fetch_ctrl.sv
`timescale 1ns/1ps
`default_nettype none
`include "fetch_defines.svh"

module fetch_ctrl (
    input  logic                      clk,
    input  logic                      rst,
    input  logic                      br_taken,
    input  logic                      ertn_flush,
    input  logic                      ex_flush,
    input  logic [`FETCH_ADDR_W-1:0]  br_target,
    input  logic [`FETCH_ADDR_W-1:0]  era,
    input  logic [`FETCH_ADDR_W-1:0]  ex_entry,
    input  logic                      busy,
    output logic                      redirect_valid,
    output logic [`FETCH_ADDR_W-1:0]  redirect_pc,
    output fetch_pkg::redirect_kind_e redirect_kind,
    output logic                      flush
);
    fetch_pkg::redirect_kind_e new_kind;
    fetch_pkg::redirect_kind_e pend_kind;
    fetch_pkg::redirect_kind_e win_kind;
    logic [`FETCH_ADDR_W-1:0]  new_pc;
    logic [`FETCH_ADDR_W-1:0]  pend_pc;
    logic [`FETCH_ADDR_W-1:0]  win_pc;
    logic                      take_new;

    // Exception entry beats exception return beats branch
    always_comb begin
        if (ex_flush) begin
            new_kind = fetch_pkg::REDIR_EXCEPTION;
            new_pc   = ex_entry;
        end else if (ertn_flush) begin
            new_kind = fetch_pkg::REDIR_ERTN;
            new_pc   = era;
        end else if (br_taken) begin
            new_kind = fetch_pkg::REDIR_BRANCH;
            new_pc   = br_target;
        end else begin
            new_kind = fetch_pkg::REDIR_NONE;
            new_pc   = br_target;
        end
    end

    // A held redirect only survives a newer one of lower rank
    assign take_new = (new_kind != fetch_pkg::REDIR_NONE) && (new_kind >= pend_kind);
    assign win_kind = take_new ? new_kind : pend_kind;
    assign win_pc   = take_new ? new_pc : pend_pc;

    assign redirect_valid = (win_kind != fetch_pkg::REDIR_NONE) && !busy;
    assign redirect_pc    = win_pc;
    assign redirect_kind  = win_kind;

    // IW drops its beat right away, even while IF still waits for accept
    assign flush = (new_kind != fetch_pkg::REDIR_NONE) ||
                   (pend_kind != fetch_pkg::REDIR_NONE);

    always_ff @(posedge clk) begin
        if (rst) begin
            pend_kind <= fetch_pkg::REDIR_NONE;
        end else if (busy) begin
            if (take_new) begin
                pend_kind <= new_kind;
            end
        end else begin
            pend_kind <= fetch_pkg::REDIR_NONE;   // Issued this cycle
        end
    end

    always_ff @(posedge clk) begin
        if (busy && take_new) begin
            pend_pc <= new_pc;
        end
    end
endmodule

`default_nettype wire

// File: src/fetch_top.sv
`timescale 1ns/1ps
`default_nettype none
`include "fetch_defines.svh"

module fetch_top (
    input  logic                     clk,
    input  logic                     rst,
    input  logic                     br_taken,
    input  logic [`FETCH_ADDR_W-1:0] br_target,
    input  logic                     ertn_flush,
    input  logic [`FETCH_ADDR_W-1:0] era,
    input  logic                     ex_flush,
    input  logic [`FETCH_ADDR_W-1:0] ex_entry,
    output logic                     mem_req,
    output logic [`FETCH_ADDR_W-1:0] mem_addr,
    input  logic                     mem_addr_ok,
    input  logic                     mem_data_ok,
    input  logic [`FETCH_ADDR_W-1:0] mem_rdata,
    output logic                     out_valid,
    input  logic                     out_ready,
    output logic [`FETCH_ADDR_W-1:0] out_inst,
    output logic [`FETCH_ADDR_W-1:0] out_pc,
    output logic                     has_exception,
    output fetch_pkg::ecode_e        ecode,
    output logic [8:0]               esubcode
);
    imem_if        mem_bus ();
    fetch_stage_if stage_bus ();

    logic                      busy;
    logic                      redirect_valid;
    logic [`FETCH_ADDR_W-1:0]  redirect_pc;
    fetch_pkg::redirect_kind_e redirect_kind;
    logic                      flush;

    assign mem_req         = mem_bus.req;
    assign mem_addr        = mem_bus.addr;
    assign mem_bus.addr_ok = mem_addr_ok;
    assign mem_bus.data_ok = mem_data_ok;
    assign mem_bus.rdata   = mem_rdata;

    fetch_ctrl u_ctrl (
        .clk            (clk),
        .rst            (rst),
        .br_taken       (br_taken),
        .ertn_flush     (ertn_flush),
        .ex_flush       (ex_flush),
        .br_target      (br_target),
        .era            (era),
        .ex_entry       (ex_entry),
        .busy           (busy),
        .redirect_valid (redirect_valid),
        .redirect_pc    (redirect_pc),
        .redirect_kind  (redirect_kind),
        .flush          (flush)
    );

    pc_gen u_if (
        .clk            (clk),
        .rst            (rst),
        .redirect_valid (redirect_valid),
        .redirect_pc    (redirect_pc),
        .redirect_kind  (redirect_kind),
        .busy           (busy),
        .mem            (mem_bus),
        .beat           (stage_bus)
    );

    inst_wait u_iw (
        .clk           (clk),
        .rst           (rst),
        .flush         (flush),
        .beat          (stage_bus),
        .mem_data_ok   (mem_bus.data_ok),
        .mem_rdata     (mem_bus.rdata),
        .out_valid     (out_valid),
        .out_ready     (out_ready),
        .out_inst      (out_inst),
        .out_pc        (out_pc),
        .has_exception (has_exception),
        .ecode         (ecode),
        .esubcode      (esubcode)
    );
endmodule

`default_nettype wire

// File: src/inst_wait.sv
`timescale 1ns/1ps
`default_nettype none
`include "fetch_defines.svh"

module inst_wait (
    input  logic                     clk,
    input  logic                     rst,
    input  logic                     flush,
    fetch_stage_if.dst               beat,
    input  logic                     mem_data_ok,
    input  logic [`FETCH_ADDR_W-1:0] mem_rdata,
    output logic                     out_valid,
    input  logic                     out_ready,
    output logic [`FETCH_ADDR_W-1:0] out_inst,
    output logic [`FETCH_ADDR_W-1:0] out_pc,
    output logic                     has_exception,
    output fetch_pkg::ecode_e        ecode,
    output logic [8:0]               esubcode
);
    logic                        held_valid;
    logic                        held_inst_valid;
    logic                        held_exc;
    logic [`FETCH_ADDR_W-1:0]    held_pc;
    logic [`FETCH_ADDR_W-1:0]    held_inst;
    fetch_pkg::ecode_e           held_ecode;
    logic [8:0]                  held_esubcode;
    logic [`FETCH_DISCARD_W-1:0] discard_cnt;

    logic                        no_discard;
    logic                        held_owed;
    logic                        data_for_held;
    logic                        data_for_in;
    logic                        in_owed;
    logic                        ready_go;
    logic                        fire_out;
    logic                        take;
    logic                        own_discard;
    logic                        discard_dec;
    logic [`FETCH_ADDR_W-1:0]    word;

    // Response order is discards first, then the held beat, then the IF slot
    assign no_discard    = (discard_cnt == '0);
    assign held_owed     = held_valid && !held_exc && !held_inst_valid;
    assign data_for_held = mem_data_ok && no_discard && held_owed;

    assign ready_go = held_valid && (held_exc || held_inst_valid || data_for_held);
    assign fire_out = ready_go && out_ready && !flush;

    assign beat.ready = !flush && (!held_valid || fire_out);
    assign take       = beat.valid && beat.ready;

    // Incoming beat whose word shows up in the same cycle
    assign in_owed     = !beat.has_exception && !beat.inst_valid;
    assign data_for_in = take && in_owed && mem_data_ok && no_discard && !held_owed;

    assign own_discard = flush && held_owed && !data_for_held;
    assign discard_dec = mem_data_ok && !no_discard;   // Stale word, dropped

    assign word = held_inst_valid ? held_inst : mem_rdata;

    always_ff @(posedge clk) begin
        if (rst) begin
            discard_cnt <= '0;
        end else begin
            discard_cnt <= discard_cnt
                         + `FETCH_DISCARD_W'(beat.discard_req)
                         + `FETCH_DISCARD_W'(own_discard)
                         - `FETCH_DISCARD_W'(discard_dec);
        end
    end

    always_ff @(posedge clk) begin
        if (rst || flush) begin
            held_valid      <= 1'b0;
            held_inst_valid <= 1'b0;
        end else if (take) begin
            held_valid      <= 1'b1;
            held_inst_valid <= beat.inst_valid || data_for_in;
        end else if (fire_out) begin
            held_valid      <= 1'b0;
            held_inst_valid <= 1'b0;
        end else if (data_for_held) begin
            held_inst_valid <= 1'b1;   // Downstream stalled, keep the word
        end
    end

    always_ff @(posedge clk) begin
        if (take) begin
            held_pc       <= beat.pc;
            held_exc      <= beat.has_exception;
            held_ecode    <= beat.ecode;
            held_esubcode <= beat.esubcode;
            held_inst     <= beat.inst_valid ? beat.inst : mem_rdata;
        end else if (data_for_held) begin
            held_inst <= mem_rdata;
        end
    end

    // A flushed output beat is wrong-path, so it goes even under back-pressure
    always_ff @(posedge clk) begin
        if (rst || flush) begin
            out_valid <= 1'b0;
        end else if (out_ready) begin
            out_valid <= ready_go;
        end
    end

    always_ff @(posedge clk) begin
        if (fire_out) begin
            out_inst      <= held_exc ? '0 : word;
            out_pc        <= held_pc;
            has_exception <= held_exc;
            ecode         <= held_ecode;
            esubcode      <= held_esubcode;
        end
    end
endmodule

`default_nettype wire

// File: src/pc_gen.sv
`timescale 1ns/1ps
`default_nettype none
`include "fetch_defines.svh"

module pc_gen (
    input  logic                      clk,
    input  logic                      rst,
    input  logic                      redirect_valid,
    input  logic [`FETCH_ADDR_W-1:0]  redirect_pc,
    input  fetch_pkg::redirect_kind_e redirect_kind,
    output logic                      busy,
    imem_if.master                    mem,
    fetch_stage_if.src                beat
);
    logic [`FETCH_ADDR_W-1:0]   pc;
    logic                       fetch_en;
    logic                       req_held;
    logic [`FETCH_DISCARD_W-1:0] out_cnt;

    logic                       slot_valid;
    logic                       slot_inst_valid;
    logic                       slot_exc;
    logic [`FETCH_ADDR_W-1:0]   slot_pc;
    logic [`FETCH_ADDR_W-1:0]   slot_inst;

    logic redir;
    logic aligned;
    logic slot_free;
    logic slot_fire;
    logic slot_owed;
    logic slot_data;
    logic issue_ok;
    logic new_req;
    logic exc_fill;
    logic accept;
    logic load;

    // Kind none carries no target
    assign redir = redirect_valid && (redirect_kind != fetch_pkg::REDIR_NONE);

    assign aligned   = (pc[1:0] == 2'b00);
    assign slot_fire = slot_valid && beat.ready;
    assign slot_free = !slot_valid || beat.ready;
    assign slot_owed = slot_valid && !slot_exc && !slot_inst_valid;

    // Outstanding count is capped so IW never holds more than three discards
    assign issue_ok = fetch_en && slot_free && !redir && !req_held && (out_cnt != '1);
    assign new_req  = issue_ok && aligned;
    assign exc_fill = issue_ok && !aligned;   // ADEF, nothing goes to memory

    assign mem.req  = req_held || new_req;
    assign mem.addr = pc;
    assign accept   = mem.req && mem.addr_ok;
    assign load     = accept || exc_fill;
    assign busy     = req_held;

    // The slot is the youngest request, so its word is the one that empties the count
    assign slot_data = mem.data_ok && slot_owed && (out_cnt == `FETCH_DISCARD_W'(1));

    always_ff @(posedge clk) begin
        if (rst) begin
            fetch_en <= 1'b0;
            req_held <= 1'b0;
            out_cnt  <= '0;
            pc       <= `FETCH_RESET_PC;
        end else begin
            fetch_en <= 1'b1;
            req_held <= mem.req && !mem.addr_ok;
            out_cnt  <= out_cnt + `FETCH_DISCARD_W'(accept) - `FETCH_DISCARD_W'(mem.data_ok);
            if (redir) begin
                pc <= redirect_pc;
            end else if (load) begin
                pc <= pc + `FETCH_ADDR_W'(4);
            end
        end
    end

    always_ff @(posedge clk) begin
        if (rst || redir) begin
            slot_valid      <= 1'b0;
            slot_inst_valid <= 1'b0;
        end else if (load) begin
            slot_valid      <= 1'b1;
            slot_inst_valid <= 1'b0;
        end else if (slot_fire) begin
            slot_valid      <= 1'b0;
            slot_inst_valid <= 1'b0;
        end else if (slot_data) begin
            slot_inst_valid <= 1'b1;   // Held here under back-pressure
        end
    end

    always_ff @(posedge clk) begin
        if (load) begin
            slot_pc  <= pc;
            slot_exc <= !aligned;
        end
        if (slot_data) begin
            slot_inst <= mem.rdata;
        end
    end

    assign beat.valid         = slot_valid;
    assign beat.pc            = slot_pc;
    assign beat.inst          = slot_inst;
    assign beat.inst_valid    = slot_inst_valid;
    assign beat.has_exception = slot_exc;
    assign beat.ecode         = slot_exc ? fetch_pkg::ECODE_ADEF : fetch_pkg::ECODE_NONE;
    assign beat.esubcode      = '0;
    // Word for a dropped slot still has to come back
    assign beat.discard_req   = redir && slot_owed && !slot_data;
endmodule

`default_nettype wire
